// File: verilog/chiplet_types_pkg.sv
// ------------------------------------------------
// link layer flit and request types
// ------------------------------------------------

package chiplet_types_pkg;

    // raw flit from the link layer
    // five bytes, byte 0 sits in bits 7:0
    typedef logic [4:0][7:0] flit_t;

    // marker selector chosen by the link layer
    // DATA_SEL sends the flit through the lane encoders
    // IDLE_SEL sends an all-zero frame
    typedef enum logic [3:0] {
        START_PACKET_SEL,
        END_PACKET_SEL,
        RESEND_PACKET0_SEL,
        RESEND_PACKET1_SEL,
        RESEND_PACKET2_SEL,
        RESEND_PACKET3_SEL,
        ACK_SEL,
        NACK_SEL,
        DATA_SEL,
        IDLE_SEL
    } comma_sel_t;

    // one transmit request, presented for a single cycle
    // start marks a valid request
    typedef struct packed {
        logic       start;
        comma_sel_t comma_sel;
        flit_t      flit;
    } tx_req_t;

endpackage

// File: verilog/phy_types_pkg.sv
// ------------------------------------------------
// 8b/10b symbol and frame types
// ------------------------------------------------

package phy_types_pkg;

    // one code group as abcdei_fghj
    // bit 9 is 'a', the first bit on the wire
    typedef logic [9:0] symbol_t;

    // K28.y commas, always in their negative-disparity form
    // abcdei is 001111 for all of them, fghj picks the marker
    typedef enum logic [9:0] {
        START_COMMA          = 10'b001111_0100,
        END_COMMA            = 10'b001111_1001,
        RESEND_PACKET0_COMMA = 10'b001111_0101,
        RESEND_PACKET1_COMMA = 10'b001111_0011,
        RESEND_PACKET2_COMMA = 10'b001111_0010,
        RESEND_PACKET3_COMMA = 10'b001111_1010,
        ACK_COMMA            = 10'b001111_0110,
        NACK_COMMA           = 10'b001111_1000
    } comma_t;

    // how many flit slots the frame takes, or data
    typedef enum logic [1:0] {
        SELECT_COMMA_1_FLIT,
        SELECT_COMMA_2_FLIT,
        SELECT_COMMA_DATA
    } comma_length_sel_t;

    // one 50-bit frame, seen either as lane symbols or as a control frame
    // data view: lane 0 in bits 9:0, lane 4 in bits 49:40
    // ctrl view: header on top, then metadata, then the fill
    typedef union packed {
        symbol_t [4:0] data;
        struct packed {
            symbol_t     header;
            symbol_t     meta_data;
            logic [29:0] fill;
        } ctrl;
    } flit_enc_t;

    // registered output toward the serializer
    typedef struct packed {
        logic              start_out;
        comma_length_sel_t comma_length_sel;
        flit_enc_t         flit_out;
    } tx_out_t;

endpackage

// File: verilog/enc_8b10b.sv
// ------------------------------------------------
// 8b/10b lane encoder
// ------------------------------------------------

module enc_8b10b
    import phy_types_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       advance,
    input  logic [7:0] data_in,
    output symbol_t    data_out
);

    // running disparity, 0 is negative and 1 is positive
    logic       rd_q;
    // disparity between the 6b and the 4b sub-block
    logic       rd_mid;
    logic       rd_next;

    // EDCBA and HGF parts of the byte
    logic [4:0] x5;
    logic [2:0] y3;

    // table codes in their RD- form
    logic [5:0] code6_neg;
    logic [3:0] code4_neg;

    // codes after disparity correction
    logic [5:0] code6;
    logic [3:0] code4;

    logic       unbal6;
    logic       unbal4;
    logic       use_a7;

    assign x5 = data_in[4:0];
    assign y3 = data_in[7:5];

    // 5b/6b table, abcdei as listed for RD-
    always_comb begin : table_5b6b
        case (x5)
            5'd0:  code6_neg = 6'b100111;
            5'd1:  code6_neg = 6'b011101;
            5'd2:  code6_neg = 6'b101101;
            5'd3:  code6_neg = 6'b110001;
            5'd4:  code6_neg = 6'b110101;
            5'd5:  code6_neg = 6'b101001;
            5'd6:  code6_neg = 6'b011001;
            // D.7 is balanced but still alternates
            5'd7:  code6_neg = 6'b111000;
            5'd8:  code6_neg = 6'b111001;
            5'd9:  code6_neg = 6'b100101;
            5'd10: code6_neg = 6'b010101;
            5'd11: code6_neg = 6'b110100;
            5'd12: code6_neg = 6'b001101;
            5'd13: code6_neg = 6'b101100;
            5'd14: code6_neg = 6'b011100;
            5'd15: code6_neg = 6'b010111;
            5'd16: code6_neg = 6'b011011;
            5'd17: code6_neg = 6'b100011;
            5'd18: code6_neg = 6'b010011;
            5'd19: code6_neg = 6'b110010;
            5'd20: code6_neg = 6'b001011;
            5'd21: code6_neg = 6'b101010;
            5'd22: code6_neg = 6'b011010;
            5'd23: code6_neg = 6'b111010;
            5'd24: code6_neg = 6'b110011;
            5'd25: code6_neg = 6'b100110;
            5'd26: code6_neg = 6'b010110;
            5'd27: code6_neg = 6'b110110;
            // D.28 data form, not the K28 comma
            5'd28: code6_neg = 6'b001110;
            5'd29: code6_neg = 6'b101110;
            5'd30: code6_neg = 6'b011110;
            default: code6_neg = 6'b101011;
        endcase
    end

    // unbalanced 6b codes carry four ones in the RD- form
    assign unbal6 = ($countones(code6_neg) != 3);

    // at RD+ the unbalanced codes and D.7 are sent complemented
    assign code6 = (rd_q && (unbal6 || (x5 == 5'd7))) ? ~code6_neg : code6_neg;
    assign rd_mid = rd_q ^ unbal6;

    // alternate D.x.7 where the primary code would leave a run of five
    assign use_a7 = (y3 == 3'd7) &&
                    ((!rd_mid && ((x5 == 5'd17) || (x5 == 5'd18) || (x5 == 5'd20))) ||
                     (rd_mid && ((x5 == 5'd11) || (x5 == 5'd13) || (x5 == 5'd14))));

    // 3b/4b table, fghj as listed for RD-
    always_comb begin : table_3b4b
        case (y3)
            3'd0: code4_neg = 4'b1011;
            3'd1: code4_neg = 4'b1001;
            3'd2: code4_neg = 4'b0101;
            // D.x.3 is balanced but still alternates
            3'd3: code4_neg = 4'b1100;
            3'd4: code4_neg = 4'b1101;
            3'd5: code4_neg = 4'b1010;
            3'd6: code4_neg = 4'b0110;
            default: code4_neg = use_a7 ? 4'b0111 : 4'b1110;
        endcase
    end

    assign unbal4 = ($countones(code4_neg) != 2);

    // sub-block disparity follows the 6b result, not the original
    assign code4 = (rd_mid && (unbal4 || (y3 == 3'd3))) ? ~code4_neg : code4_neg;

    // net flip only when exactly one sub-block is unbalanced
    assign rd_next = rd_mid ^ unbal4;

    assign data_out = {code6, code4};

    // disparity moves only for symbols that are actually sent as data
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_q <= 1'b0;
        end else if (advance) begin
            rd_q <= rd_next;
        end
    end

endmodule

// File: verilog/wrap_enc_8b_10b.sv
// ------------------------------------------------
// five-lane encoder and frame builder
// ------------------------------------------------

module wrap_enc_8b_10b
    import chiplet_types_pkg::*;
    import phy_types_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  tx_req_t req,
    output tx_out_t tx
);

    // per-lane symbols, then collected into the data view
    symbol_t           lane_sym [5];
    flit_enc_t         data_view;
    logic              lane_adv;

    // next frame and length, before the output register
    flit_enc_t         n_flit;
    comma_length_sel_t n_len;

    // header comma for each marker
    function automatic comma_t comma_for(input comma_sel_t sel);
        case (sel)
            START_PACKET_SEL:   return START_COMMA;
            END_PACKET_SEL:     return END_COMMA;
            RESEND_PACKET0_SEL: return RESEND_PACKET0_COMMA;
            RESEND_PACKET1_SEL: return RESEND_PACKET1_COMMA;
            RESEND_PACKET2_SEL: return RESEND_PACKET2_COMMA;
            RESEND_PACKET3_SEL: return RESEND_PACKET3_COMMA;
            ACK_SEL:            return ACK_COMMA;
            default:            return NACK_COMMA;
        endcase
    endfunction

    // lanes only step their disparity on a started data flit
    assign lane_adv = req.start && (req.comma_sel == DATA_SEL);

    for (genvar i = 0; i < 5; i++) begin : g_lane
        enc_8b10b u_enc (
            .CLK      (CLK),
            .nRST     (nRST),
            .advance  (lane_adv),
            .data_in  (req.flit[i]),
            .data_out (lane_sym[i])
        );
    end

    always_comb begin
        for (int i = 0; i < 5; i++) begin
            data_view.data[i] = lane_sym[i];
        end
    end

    // frame selection
    always_comb begin
        n_flit = '0;
        n_len  = SELECT_COMMA_1_FLIT;
        case (req.comma_sel)
            START_PACKET_SEL, END_PACKET_SEL: begin
                n_flit.ctrl.header    = comma_for(req.comma_sel);
                n_flit.ctrl.meta_data = '1;
                n_flit.ctrl.fill      = '1;
                n_len                 = SELECT_COMMA_1_FLIT;
            end
            RESEND_PACKET0_SEL, RESEND_PACKET1_SEL, RESEND_PACKET2_SEL,
            RESEND_PACKET3_SEL, ACK_SEL, NACK_SEL: begin
                n_flit.ctrl.header    = comma_for(req.comma_sel);
                // byte 0 at lane 0's current disparity, lane not advanced
                n_flit.ctrl.meta_data = lane_sym[0];
                n_flit.ctrl.fill      = '1;
                n_len                 = SELECT_COMMA_2_FLIT;
            end
            DATA_SEL: begin
                n_flit = data_view;
                n_len  = SELECT_COMMA_DATA;
            end
            // IDLE_SEL keeps the all-zero frame
            default: begin
            end
        endcase
    end

    // output register toward the serializer
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tx.start_out        <= 1'b0;
            tx.flit_out         <= '0;
            tx.comma_length_sel <= SELECT_COMMA_1_FLIT;
        end else begin
            tx.start_out        <= req.start;
            // frame is captured every cycle, start or not
            tx.flit_out         <= n_flit;
            tx.comma_length_sel <= req.start ? n_len : SELECT_COMMA_1_FLIT;
        end
    end

endmodule

// File: verilog/phy_tx_top.sv
// ------------------------------------------------
// chiplet PHY transmit top
// ------------------------------------------------

module phy_tx_top
    import chiplet_types_pkg::*;
    import phy_types_pkg::*;
(
    // link clock and async active-low reset
    input  logic    CLK,
    input  logic    nRST,

    // request from the link layer
    // start, marker selector and the 40-bit flit
    input  tx_req_t req,

    // registered frame for the serializer
    // one cycle after the request
    output tx_out_t tx
);

    // request straight into the encoder wrapper
    tx_req_t req_w;

    // registered frame from the wrapper
    tx_out_t tx_w;

    assign req_w = req;

    // five lanes of 8b/10b plus the control frame builder
    wrap_enc_8b_10b u_wrap (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (req_w),
        .tx   (tx_w)
    );

    // already registered inside the wrapper, no extra stage
    assign tx = tx_w;

endmodule

// File: tests/tx_props.sv
// ------------------------------------------------
// transmit wrapper assertions
// ------------------------------------------------

module tx_props
    import chiplet_types_pkg::*;
    import phy_types_pkg::*;
(
    input logic    CLK,
    input logic    nRST,
    input tx_req_t req,
    input tx_out_t tx
);

    // every lane symbol carries four, five or six ones
    function automatic logic lanes_balanced(input flit_enc_t f);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 5; i++) begin
            if (($countones(f.data[i]) < 4) || ($countones(f.data[i]) > 6)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // start_out is the request strobe one cycle late
    start_delay: assert property (@(posedge CLK) disable iff (!nRST)
        tx.start_out == $past(req.start))
        else $error("start_out does not follow start by one cycle");

    // length select parks at one flit when nothing was started
    idle_length: assert property (@(posedge CLK) disable iff (!nRST)
        !tx.start_out |-> (tx.comma_length_sel == SELECT_COMMA_1_FLIT))
        else $error("length select is not one flit while start_out is low");

    // data symbols never exceed a disparity of two
    data_disparity: assert property (@(posedge CLK) disable iff (!nRST)
        (tx.start_out && (tx.comma_length_sel == SELECT_COMMA_DATA))
            |-> lanes_balanced(tx.flit_out))
        else $error("data symbol with disparity outside 0 or +-2");

endmodule

bind wrap_enc_8b_10b tx_props u_props (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .tx   (tx)
);

// File: tests/tx_checker.sv
// ------------------------------------------------
// transmit output checker
// ------------------------------------------------

module tx_checker
    import chiplet_types_pkg::*;
    import phy_types_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  tx_req_t           req,
    input  tx_out_t           tx,
    input  comma_length_sel_t exp_len,
    input  flit_enc_t         exp_frame,
    input  int                test_idx,
    output int                error_count,
    output int                check_count
);

    // one request in flight, seen at the edge that samples it
    logic              pend_valid;
    comma_length_sel_t pend_len;
    flit_enc_t         pend_frame;
    int                pend_idx;
    logic              first_cycle;

    int                err_cnt = 0;
    int                chk_cnt = 0;

    assign error_count = err_cnt;
    assign check_count = chk_cnt;

    // compare the registered frame of one request
    task automatic compare_frame();
        if (tx.start_out !== 1'b1) begin
            $display("start_out missing for req%0d", pend_idx);
            err_cnt++;
        end
        if (tx.comma_length_sel !== pend_len) begin
            $display("FAIL req%0d comma_length_sel expected %0d actual %0d",
                     pend_idx, pend_len, tx.comma_length_sel);
            err_cnt++;
        end
        if (tx.flit_out !== pend_frame) begin
            $display("FAIL req%0d flit_out expected %h actual %h",
                     pend_idx, pend_frame, tx.flit_out);
            err_cnt++;
        end
        chk_cnt++;
    endtask

    // values are read before this edge's register update
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pend_valid  <= 1'b0;
            first_cycle <= 1'b1;
        end else begin
            if (first_cycle) begin
                if ((tx.flit_out !== '0) || (tx.comma_length_sel !== SELECT_COMMA_1_FLIT)) begin
                    $display("output is not cleared after reset");
                    err_cnt++;
                end
                first_cycle <= 1'b0;
            end
            if (pend_valid) begin
                compare_frame();
            end else if ((tx.start_out !== 1'b0) ||
                         (tx.comma_length_sel !== SELECT_COMMA_1_FLIT)) begin
                $display("output shows a frame although no request was started");
                err_cnt++;
            end
            pend_valid <= req.start;
            pend_len   <= exp_len;
            pend_frame <= exp_frame;
            pend_idx   <= test_idx;
        end
    end

endmodule

// File: tests/tb_phy_tx.sv
// ------------------------------------------------
// chiplet PHY transmit testbench
// ------------------------------------------------

module tb_phy_tx
    import chiplet_types_pkg::*;
    import phy_types_pkg::*;
();

    logic              CLK;
    logic              nRST;
    tx_req_t           req;
    tx_out_t           tx;
    comma_length_sel_t exp_len;
    flit_enc_t         exp_frame;
    int                test_idx;
    int                error_count;
    int                check_count;

    // requests read from the stimulus file
    logic [3:0]        sel_mem   [64];
    logic [39:0]       flit_mem  [64];
    logic [1:0]        len_mem   [64];
    logic [49:0]       frame_mem [64];
    int                n_req = 0;

    logic [7:0]        lfsr = 8'd13;
    int                cycle_cnt = 0;
    int                timeout_limit = 0;

    phy_tx_top dut (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (req),
        .tx   (tx)
    );

    tx_checker u_checker (
        .CLK         (CLK),
        .nRST        (nRST),
        .req         (req),
        .tx          (tx),
        .exp_len     (exp_len),
        .exp_frame   (exp_frame),
        .test_idx    (test_idx),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // galois lfsr with taps x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit and two bits per gap of 0 to 3
    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            bits[b] = lfsr[0];
            lfsr    = lfsr_next(lfsr);
        end
        gap = bits;
    endtask

    task automatic load_stimulus();
        int         fd;
        int         cnt;
        string      line;
        logic [9:0] s4, s3, s2, s1, s0;
        fd = $fopen("tests/tx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if ((line.len() > 0) && (line[0] != "#")) begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", sel_mem[n_req],
                                  flit_mem[n_req], len_mem[n_req], s4, s3, s2, s1, s0);
                    if (cnt == 8) begin
                        frame_mem[n_req] = {s4, s3, s2, s1, s0};
                        n_req++;
                    end
                end
            end
            $fclose(fd);
            if (n_req == 0) begin
                $display("no requests found in the stimulus file");
            end
        end
    endtask

    // cycle limit from the number of requests and the widest gap
    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if ((timeout_limit > 0) && (cycle_cnt >= timeout_limit)) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int gap;
        nRST      = 1'b0;
        req       = '{start: 1'b0, comma_sel: IDLE_SEL, flit: '0};
        exp_len   = SELECT_COMMA_1_FLIT;
        exp_frame = '0;
        test_idx  = 0;
        load_stimulus();
        timeout_limit = n_req * (1 + 3) + 20;

        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);

        for (int i = 0; i < n_req; i++) begin
            @(posedge CLK);
            req       <= '{start: 1'b1, comma_sel: comma_sel_t'(sel_mem[i]), flit: flit_mem[i]};
            exp_len   <= comma_length_sel_t'(len_mem[i]);
            exp_frame <= frame_mem[i];
            test_idx  <= i;
            draw_gap(gap);
            // unbalanced data bytes without start must not step any lane
            repeat (gap) begin
                @(posedge CLK);
                req <= '{start: 1'b0, comma_sel: DATA_SEL, flit: 40'h2020202020};
            end
        end
        @(posedge CLK);
        req <= '{start: 1'b0, comma_sel: IDLE_SEL, flit: '0};

        // wait for the checker to see every frame
        while (check_count < n_req) begin
            @(posedge CLK);
        end
        @(posedge CLK);

        $display("errors %0d, frames checked %0d of %0d", error_count, check_count, n_req);
        if ((error_count == 0) && (n_req > 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tests/tx_stimulus.txt
# columns: comma_sel flit(byte4..byte0) length_sel then five 10-bit frame fields
# frame fields run from bits 49:40 down to bits 9:0, all values in hex
# plain data, disparity stays negative
8 0000000000 2 274 274 274 274 274
8 FFFFFFFFFF 2 2B1 2B1 2B1 2B1 2B1
# unbalanced bytes flip every lane to positive
8 2003F1EB20 2 279 31B 237 34E 279
6 0000000020 1 0F6 189 3FF 3FF 3FF
8 2003F1EB20 2 189 314 231 348 189
# only lane 0 moves
8 0000000020 2 274 274 274 274 279
0 1234567890 0 0F4 3FF 3FF 3FF 3FF
7 0000000007 1 0F8 074 3FF 3FF 3FF
8 0707070707 2 38B 38B 38B 38B 074
1 0000000000 0 0F9 3FF 3FF 3FF 3FF
9 FFFFFFFFFF 0 000 000 000 000 000
# resend markers use lane 0 at its held disparity
2 0000000003 1 0F5 31B 3FF 3FF 3FF
3 00000000BC 1 0F3 0EA 3FF 3FF 3FF
4 0000000000 1 0F2 274 3FF 3FF 3FF
5 00000000FF 1 0FA 2B1 3FF 3FF 3FF
# lanes with mixed histories
8 BC3C0320BC 2 0EA 0E9 314 189 0EA
8 2020202020 2 189 189 279 279 279
8 FFFFFFFFFF 2 2B1 2B1 14E 14E 14E
8 0000000000 2 274 274 18B 18B 18B
8 6363636363 2 31C 31C 313 313 313
6 0000000020 1 0F6 189 3FF 3FF 3FF
8 2020202020 2 279 279 189 189 189

// File: all.f
verilog/chiplet_types_pkg.sv
verilog/phy_types_pkg.sv
verilog/enc_8b10b.sv
verilog/wrap_enc_8b_10b.sv
verilog/phy_tx_top.sv
tests/tx_props.sv
tests/tx_checker.sv
tests/tb_phy_tx.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_phy_tx -f all.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
